/* common/sw_pkg.sv */
// smith-waterman shared definitions
package sw_pkg;

    // job sizes
    localparam int REF_MAX_LEN = 16;
    localparam int READ_MAX_LEN = 8;
    localparam int SCORE_W = 8;
    localparam int REF_LEN_W = 5;
    localparam int READ_LEN_W = 4;
    localparam int COL_W = 4;
    localparam int ROW_W = 3;
    // wide enough for ref_len + read_len
    localparam int CNT_W = REF_LEN_W + 1;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // affine scoring
    localparam score_t MATCH_SCORE = 2;
    localparam score_t MISMATCH_SCORE = -1;
    localparam score_t GAP_OPEN = -2;
    localparam score_t GAP_EXTEND = -1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_CALC,
        ST_SELECT,
        ST_DONE
    } sw_state_e;

    typedef enum logic [1:0] {
        BASE_A,
        BASE_C,
        BASE_G,
        BASE_T
    } base_e;

    typedef struct packed {
        score_t h;
        score_t e;
        score_t f;
    } score_cell_t;

    // base 0 in the top bits of each sequence
    typedef struct packed {
        logic [2*REF_MAX_LEN-1:0] ref_seq;
        logic [2*READ_MAX_LEN-1:0] read_seq;
        logic [REF_LEN_W-1:0] ref_len;
        logic [READ_LEN_W-1:0] read_len;
    } sw_job_t;

    typedef struct packed {
        score_t score;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } sw_result_t;

    typedef struct packed {
        score_t score;
        logic [COL_W-1:0] col;
    } row_best_t;

endpackage

/* sw_array/sw_pe.sv */
// systolic processing element
`timescale 1ns/1ns
module sw_pe (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_clear,
    input  logic                i_row_en,
    input  logic                i_base_valid,
    input  sw_pkg::base_e       i_ref_base,
    input  sw_pkg::base_e       i_read_base,
    input  sw_pkg::score_cell_t i_top,
    output logic                o_base_valid,
    output sw_pkg::base_e       o_ref_base,
    output sw_pkg::score_cell_t o_cell,
    output sw_pkg::row_best_t   o_row_best
);

    sw_pkg::score_t s;
    sw_pkg::score_t diag_h_q;
    sw_pkg::score_cell_t cell_d;
    logic [sw_pkg::COL_W-1:0] col_q;

    function automatic sw_pkg::score_t max2(input sw_pkg::score_t a, input sw_pkg::score_t b);
        return (a > b) ? a : b;
    endfunction

    // o_cell doubles as the left neighbour, diag_h_q as the diagonal
    always_comb begin
        s = (i_ref_base == i_read_base) ? sw_pkg::MATCH_SCORE : sw_pkg::MISMATCH_SCORE;
        cell_d.e = max2(max2('0, o_cell.h + sw_pkg::GAP_OPEN), o_cell.e + sw_pkg::GAP_EXTEND);
        cell_d.f = max2(max2('0, i_top.h + sw_pkg::GAP_OPEN), i_top.f + sw_pkg::GAP_EXTEND);
        cell_d.h = max2(max2('0, diag_h_q + s), max2(cell_d.e, cell_d.f));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_base_valid <= 1'b0;
            o_cell <= '0;
            diag_h_q <= '0;
            col_q <= '0;
            o_row_best <= '0;
        end else if (i_clear) begin
            o_base_valid <= 1'b0;
            o_cell <= '0;
            diag_h_q <= '0;
            col_q <= '0;
            o_row_best <= '0;
        end else begin
            o_base_valid <= i_base_valid;
            // top cell of the previous column
            diag_h_q <= i_top.h;
            if (i_base_valid && i_row_en) begin
                o_cell <= cell_d;
                col_q <= col_q + 1'b1;
                // strict compare keeps the earliest column on ties
                if (cell_d.h > o_row_best.score) begin
                    o_row_best.score <= cell_d.h;
                    o_row_best.col <= col_q;
                end
            end
        end
    end

    // base moves on to the next row
    always_ff @(posedge clk) begin
        o_ref_base <= i_ref_base;
    end

endmodule

/* sw_array/sw_array.sv */
// linear systolic array
`timescale 1ns/1ns
module sw_array (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_clear,
    input  logic                                         i_base_valid,
    input  sw_pkg::base_e                                i_ref_base,
    input  logic [2*sw_pkg::READ_MAX_LEN-1:0]            i_read_seq,
    input  logic [sw_pkg::READ_LEN_W-1:0]                i_read_len,
    output sw_pkg::row_best_t [sw_pkg::READ_MAX_LEN-1:0] o_row_best
);

    // index 0 is the boundary row feeding element 0
    logic chain_valid [sw_pkg::READ_MAX_LEN+1];
    sw_pkg::base_e chain_base [sw_pkg::READ_MAX_LEN+1];
    sw_pkg::score_cell_t chain_cell [sw_pkg::READ_MAX_LEN+1];

    assign chain_valid[0] = i_base_valid;
    assign chain_base[0] = i_ref_base;
    assign chain_cell[0] = '0;

    for (genvar k = 0; k < sw_pkg::READ_MAX_LEN; k++) begin : g_pe
        sw_pkg::base_e read_base;
        logic row_en;

        assign read_base = sw_pkg::base_e'(i_read_seq[2*sw_pkg::READ_MAX_LEN-1-2*k -: 2]);
        // rows past the read stay idle
        assign row_en = (k < int'(i_read_len));

        sw_pe u_pe (
            .clk          (clk),
            .rst          (rst),
            .i_clear      (i_clear),
            .i_row_en     (row_en),
            .i_base_valid (chain_valid[k]),
            .i_ref_base   (chain_base[k]),
            .i_read_base  (read_base),
            .i_top        (chain_cell[k]),
            .o_base_valid (chain_valid[k+1]),
            .o_ref_base   (chain_base[k+1]),
            .o_cell       (chain_cell[k+1]),
            .o_row_best   (o_row_best[k])
        );
    end

endmodule

/* source/sw_ctrl.sv */
// aligner job controller
`timescale 1ns/1ns
module sw_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_valid,
    input  sw_pkg::sw_job_t                              i_job,
    input  logic                                         i_ready,
    input  sw_pkg::row_best_t [sw_pkg::READ_MAX_LEN-1:0] i_row_best,
    output logic                                         o_ready,
    output logic                                         o_valid,
    output sw_pkg::sw_result_t                           o_result,
    output logic                                         o_clear,
    output logic                                         o_base_valid,
    output sw_pkg::base_e                                o_ref_base,
    output logic [2*sw_pkg::READ_MAX_LEN-1:0]            o_read_seq,
    output logic [sw_pkg::READ_LEN_W-1:0]                o_read_len
);

    sw_pkg::sw_state_e state_q;
    sw_pkg::cnt_t cnt_q;
    sw_pkg::cnt_t calc_last;
    sw_pkg::cnt_t sel_last;
    sw_pkg::sw_job_t job_q;
    logic [2*sw_pkg::REF_MAX_LEN-1:0] ref_sr_q;
    logic [sw_pkg::ROW_W-1:0] sel_row;
    sw_pkg::sw_result_t result_q;

    // calc runs long enough for the last row to drain
    assign calc_last = sw_pkg::cnt_t'(job_q.ref_len) + sw_pkg::cnt_t'(job_q.read_len) - 1'b1;
    assign sel_last = sw_pkg::cnt_t'(job_q.read_len) - 1'b1;
    assign sel_row = cnt_q[sw_pkg::ROW_W-1:0];

    assign o_ready = (state_q == sw_pkg::ST_IDLE);
    assign o_valid = (state_q == sw_pkg::ST_DONE);
    assign o_result = result_q;
    assign o_clear = (state_q == sw_pkg::ST_LOAD);
    assign o_base_valid = (state_q == sw_pkg::ST_CALC) && (cnt_q < sw_pkg::cnt_t'(job_q.ref_len));
    assign o_ref_base = sw_pkg::base_e'(ref_sr_q[2*sw_pkg::REF_MAX_LEN-1 -: 2]);
    assign o_read_seq = job_q.read_seq;
    assign o_read_len = job_q.read_len;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= sw_pkg::ST_IDLE;
            cnt_q <= '0;
            result_q <= '0;
        end else begin
            case (state_q)
                sw_pkg::ST_IDLE: begin
                    if (i_valid) begin
                        state_q <= sw_pkg::ST_LOAD;
                    end
                end
                sw_pkg::ST_LOAD: begin
                    state_q <= sw_pkg::ST_CALC;
                    cnt_q <= '0;
                end
                sw_pkg::ST_CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == calc_last) begin
                        state_q <= sw_pkg::ST_SELECT;
                        cnt_q <= '0;
                    end
                end
                sw_pkg::ST_SELECT: begin
                    cnt_q <= cnt_q + 1'b1;
                    // row 0 seeds the scan, later rows must beat it
                    if (cnt_q == '0 || i_row_best[sel_row].score > result_q.score) begin
                        result_q.score <= i_row_best[sel_row].score;
                        result_q.row <= sel_row;
                        result_q.col <= i_row_best[sel_row].col;
                    end
                    if (cnt_q == sel_last) begin
                        state_q <= sw_pkg::ST_DONE;
                    end
                end
                sw_pkg::ST_DONE: begin
                    if (i_ready) begin
                        state_q <= sw_pkg::ST_IDLE;
                    end
                end
                default: state_q <= sw_pkg::ST_IDLE;
            endcase
        end
    end

    // job latch and reference shifter
    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            job_q <= i_job;
            ref_sr_q <= i_job.ref_seq;
        end else if (state_q == sw_pkg::ST_CALC) begin
            ref_sr_q <= {ref_sr_q[2*sw_pkg::REF_MAX_LEN-3:0], 2'b00};
        end
    end

endmodule

/* source/sw_core.sv */
// smith-waterman aligner top
`timescale 1ns/1ns
module sw_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_valid,
    input  sw_pkg::sw_job_t    i_job,
    output logic               o_ready,
    input  logic               i_ready,
    output logic               o_valid,
    output sw_pkg::sw_result_t o_result
);

    logic clear;
    logic base_valid;
    sw_pkg::base_e ref_base;
    logic [2*sw_pkg::READ_MAX_LEN-1:0] read_seq;
    logic [sw_pkg::READ_LEN_W-1:0] read_len;
    sw_pkg::row_best_t [sw_pkg::READ_MAX_LEN-1:0] row_best;

    sw_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_job        (i_job),
        .i_ready      (i_ready),
        .i_row_best   (row_best),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_clear      (clear),
        .o_base_valid (base_valid),
        .o_ref_base   (ref_base),
        .o_read_seq   (read_seq),
        .o_read_len   (read_len)
    );

    // one element per read row
    sw_array u_array (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (clear),
        .i_base_valid (base_valid),
        .i_ref_base   (ref_base),
        .i_read_seq   (read_seq),
        .i_read_len   (read_len),
        .o_row_best   (row_best)
    );

endmodule

/* dv/sw_core_assert.sv */
// aligner protocol assertions
`timescale 1ns/1ns
module sw_core_assert (
    input logic               clk,
    input logic               rst,
    input logic               i_ready,
    input logic               o_ready,
    input logic               o_valid,
    input sw_pkg::sw_result_t o_result
);

    // ready and valid come from different states
    a_ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_ready && o_valid))
        else $error("o_ready and o_valid high together");

    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=> $stable(o_result))
        else $error("o_result changed while the sink held off");

    a_valid_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !o_valid)
        else $error("o_valid high in the cycle after reset");

    a_score_sign: assert property (@(posedge clk) disable iff (rst)
        o_valid |-> !o_result.score[sw_pkg::SCORE_W-1])
        else $error("negative result score");

endmodule

bind sw_core sw_core_assert u_assert (.*);

/* dv/tb_sw_core.sv */
// smith-waterman aligner testbench
`timescale 1ns/1ns
module tb_sw_core;

    localparam int CLK_PERIOD = 8;
    // room for 14 jobs of up to 60 cycles each
    localparam int MAX_CYCLES = 14 * 60 + 100;

    logic clk;
    logic rst;
    logic i_valid;
    sw_pkg::sw_job_t i_job;
    logic o_ready;
    logic i_ready;
    logic o_valid;
    sw_pkg::sw_result_t o_result;

    logic [31:0] lcg_state;
    int cycle_count = 0;
    int job_count = 0;

    sw_core u_dut (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_job    (i_job),
        .o_ready  (o_ready),
        .i_ready  (i_ready),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycle_count);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    // stray job offers while the core is busy
    task automatic drive_noise();
        logic [31:0] r;
        r = next_random();
        i_valid = 1'b0;
        if (!o_ready && r[20]) begin
            i_valid = 1'b1;
            i_job.ref_seq = next_random();
            i_job.read_seq = r[15:0];
            i_job.ref_len = r[25:21];
            i_job.read_len = r[29:26];
        end
    endtask

    task automatic check_result(input sw_pkg::sw_result_t expected);
        check_value("o_valid", 1, int'(o_valid));
        check_value("o_ready", 0, int'(o_ready));
        check_value("o_result.score", int'(expected.score), int'(o_result.score));
        check_value("o_result.row", int'(expected.row), int'(o_result.row));
        check_value("o_result.col", int'(expected.col), int'(o_result.col));
    endtask

    task automatic run_job(input sw_pkg::sw_job_t job, input sw_pkg::sw_result_t expected);
        logic [31:0] r;
        logic [2:0] stall;
        check_value("o_ready", 1, int'(o_ready));
        i_job = job;
        i_valid = 1'b1;
        @(negedge clk);
        while (!o_valid) begin
            drive_noise();
            @(negedge clk);
        end
        r = next_random();
        stall = r[18:16];
        check_result(expected);
        // sink holds off, result must not move
        repeat (stall) begin
            drive_noise();
            @(negedge clk);
            check_result(expected);
        end
        i_valid = 1'b0;
        i_ready = 1'b1;
        @(negedge clk);
        i_ready = 1'b0;
        check_value("o_valid", 0, int'(o_valid));
        check_value("o_ready", 1, int'(o_ready));
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [31:0] ref_len;
        logic [31:0] read_len;
        logic [31:0] ref_seq;
        logic [31:0] read_seq;
        logic [31:0] exp_score;
        logic [31:0] exp_row;
        logic [31:0] exp_col;
        sw_pkg::sw_job_t job;
        sw_pkg::sw_result_t expected;

        lcg_state = 32'he7ed;
        rst = 1'b1;
        i_valid = 1'b0;
        i_job = '0;
        i_ready = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_ready", 1, int'(o_ready));
        check_value("o_valid", 0, int'(o_valid));

        fd = $fopen("dv/sw_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file dv/sw_stim.txt");
            $display("Test failures found");
            $fatal(1, "missing stimulus");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", ref_len, read_len,
                            ref_seq, read_seq, exp_score, exp_row, exp_col);
                if (n == 7) begin
                    job.ref_seq = ref_seq;
                    job.read_seq = read_seq[15:0];
                    job.ref_len = ref_len[4:0];
                    job.read_len = read_len[3:0];
                    expected.score = exp_score[7:0];
                    expected.row = exp_row[2:0];
                    expected.col = exp_col[3:0];
                    run_job(job, expected);
                    job_count++;
                end
            end
        end
        $fclose(fd);

        if (job_count > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("ERROR: no job from the stimulus file was checked");
            $display("Test failures found");
            $fatal(1, "no jobs");
        end
    end

endmodule

/* dv/sw_stim.txt */
# ref_len read_len ref_seq read_seq score row col, all hex
# bases A=0 C=1 G=2 T=3, base 0 in the top bits of each sequence
04 4 1b000000 1b00 08 3 3
05 5 17800000 1b80 07 4 4
06 4 10b00000 1b00 05 3 5
05 2 18400000 1000 04 1 1
02 4 10000000 1100 04 1 1
04 3 55000000 0000 00 0 0
01 1 80000000 8000 02 0 0
01 1 c0000000 0000 00 0 0
10 8 ff1b1bff 1b1b 10 7 b
10 8 aaaaaaaa aaaa 10 7 7
10 8 ffffffff 0000 00 0 0
10 8 00000001 5555 02 0 f

/* sw_core.f */
common/sw_pkg.sv
sw_array/sw_pe.sv
sw_array/sw_array.sv
source/sw_ctrl.sv
source/sw_core.sv
dv/sw_core_assert.sv
dv/tb_sw_core.sv

/* run.sh */
#!/bin/sh
# build and run the aligner testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_sw_core -Mdir obj_dir -f sw_core.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_sw_core)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1
